/* tb.f */
+incdir+.
pinmux_pkg.sv
pad_sel_if.sv
pinmux_ctrl.sv
pad_drive.sv
pad_capture.sv
pinmux_top.sv
tb_pinmux.sv

/* tb_pinmux_model.svh */
// Reference model of the pad multiplexer
// Expected pad outputs and steered peripheral inputs, built from the
// owner priority rule and the fixed pad maps

`ifndef TB_PINMUX_MODEL_SVH
`define TB_PINMUX_MODEL_SVH

// Pad driven by PWM k
localparam int PWM_PADS [6] = '{27, 29, 30, 9, 10, 11};

// WS channel wired to a pad, -1 where there is none
function automatic int ws_ch_of(input int p);
  case (p)
    22, 24, 25, 26: return 0;
    27, 28, 14, 15: return 1;
    29, 30, 31, 8:  return 2;
    9, 10, 11, 12:  return 3;
    default:        return -1;
  endcase
endfunction

// Enabled PWM landing on a pad, -1 where there is none
function automatic int pwm_of(input logic [31:0] func, input int p);
  for (int k = 0; k < 6; k++) begin
    if (func[k] && PWM_PADS[k] == p)
      return k;
  end
  return -1;
endfunction

// Peripheral word holds {scl_oen, scl_o, sda_oen, sda_o, uart_tx, pwm, ws, gpio}
// Result is {oen, out}
function automatic logic [63:0] exp_pad(input logic [31:0] dir, input logic [31:0] otype,
                                        input logic [31:0] func, input logic [47:0] per);
  logic [31:0] out;
  logic [31:0] oen;
  logic        in_only;
  int          ch;
  int          k;
  for (int p = 0; p < 32; p++) begin
    out[p] = 1'b0;
    oen[p] = 1'b0;
    ch     = ws_ch_of(p);
    k      = pwm_of(func, p);
    // RX pads and enabled interrupt pads stay inputs
    in_only = (func[8] && p == 24) || (func[9] && p == 26) ||
              (func[6] && p == 26) || (func[7] && p == 27);
    if (k >= 0) out[p] = per[36 + k];
    else if (func[8] && p == 25) out[p] = per[42];
    else if (func[9] && p == 28) out[p] = per[43];
    else if (func[15] && p == 20) {oen[p], out[p]} = per[45:44];
    else if (func[15] && p == 21) {oen[p], out[p]} = per[47:46];
    else if (in_only) oen[p] = 1'b1;
    else if (otype[p] && ch >= 0) out[p] = per[32 + ch];
    else if (dir[p]) out[p] = per[p];
    else oen[p] = 1'b1;
  end
  return {oen, out};
endfunction

// Result is {scl, sda, ext_intr[1:0], uart_rxd[1:0]}
function automatic logic [5:0] exp_in(input logic [31:0] func, input logic [31:0] pads);
  logic [5:0] r;
  // Idle high when a UART is off
  r[0] = func[8] ? pads[24] : 1'b1;
  r[1] = func[9] ? pads[26] : 1'b1;
  // UART 1 RX takes pad 26 away from INT0
  r[2] = (func[6] && !func[9]) ? pads[26] : 1'b0;
  r[3] = func[7] ? pads[27] : 1'b0;
  r[4] = func[15] ? pads[20] : 1'b0;
  r[5] = func[15] ? pads[21] : 1'b0;
  return r;
endfunction

`endif

/* tb_pinmux.sv */
// Testbench for the pad multiplexer
// Random configuration, peripheral and pad stimulus checked every cycle
// against a reference model of the pipelined selection

`include "pinmux_cfg.svh"

module tb_pinmux;

  logic        mclk_i;
  logic        rst_i;
  logic [31:0] cfg_gpio_dir_sel_i;
  logic [31:0] cfg_gpio_out_type_i;
  logic [31:0] cfg_multi_func_sel_i;
  logic [31:0] gpio_out_i;
  logic [31:0] pad_gpio_in_o;
  logic [3:0]  ws_txd_i;
  logic [5:0]  pwm_wfm_i;
  logic [1:0]  uart_txd_i;
  logic [1:0]  uart_rxd_o;
  logic [1:0]  ext_intr_o;
  logic        i2c_sda_o_i;
  logic        i2c_sda_oen_i;
  logic        i2c_scl_o_i;
  logic        i2c_scl_oen_i;
  logic        i2c_sda_i_o;
  logic        i2c_scl_i_o;
  logic [31:0] digital_io_in_i;
  logic [31:0] digital_io_out_o;
  logic [31:0] digital_io_oen_o;

  integer seed;
  int     live_n;
  int     n_checks;

  // Input history with index 0 as the current cycle
  logic [31:0] dir_h  [3];
  logic [31:0] type_h [3];
  logic [31:0] func_h [3];
  logic [31:0] pad_h  [3];
  logic [47:0] per_h  [2];

  `include "tb_pinmux_model.svh"

  pinmux_top i_dut (.*);

  always #2 mclk_i = ~mclk_i;

  // ----------------------------------------------------------
  // Failure reporting and waits
  // ----------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    string line;
    line = $sformatf("MISMATCH time=%0t %s expected=%0h actual=%0h",
                     $time, sig, exp_v, act_v);
    abort_run(line);
  endtask

  // Compare process needs two cycles of history after reset
  task automatic wait_checker_live();
    int t;
    t = 0;
    while (live_n < 3 && t < 16) begin
      @(negedge mclk_i);
      t++;
    end
    if (live_n < 3)
      abort_run("compare process did not start after reset was released");
  endtask

  // One cycle of stimulus with fresh random peripheral and pad values
  task automatic drive_cycle(input logic [31:0] dir, input logic [31:0] otype,
                             input logic [31:0] func);
    @(posedge mclk_i);
    #1;
    cfg_gpio_dir_sel_i   = dir;
    cfg_gpio_out_type_i  = otype;
    cfg_multi_func_sel_i = func;
    gpio_out_i           = $random(seed);
    ws_txd_i             = $random(seed);
    pwm_wfm_i            = $random(seed);
    uart_txd_i           = $random(seed);
    {i2c_scl_oen_i, i2c_scl_o_i, i2c_sda_oen_i, i2c_sda_o_i} = $random(seed);
    digital_io_in_i      = $random(seed);
  endtask

  // ----------------------------------------------------------
  // Compare process sampled mid-cycle
  // ----------------------------------------------------------
  always @(negedge mclk_i) begin : compare
    logic [63:0] pad_exp;
    logic [5:0]  in_exp;
    if (rst_i) begin
      live_n = 0;
    end else begin
      for (int i = 2; i > 0; i--) begin
        dir_h[i]  = dir_h[i-1];
        type_h[i] = type_h[i-1];
        func_h[i] = func_h[i-1];
        pad_h[i]  = pad_h[i-1];
      end
      per_h[1]  = per_h[0];
      dir_h[0]  = cfg_gpio_dir_sel_i;
      type_h[0] = cfg_gpio_out_type_i;
      func_h[0] = cfg_multi_func_sel_i;
      pad_h[0]  = digital_io_in_i;
      per_h[0]  = {i2c_scl_oen_i, i2c_scl_o_i, i2c_sda_oen_i, i2c_sda_o_i,
                   uart_txd_i, pwm_wfm_i, ws_txd_i, gpio_out_i};
      live_n++;
      if (live_n >= 3) begin
        // Config from two cycles back and peripherals from one cycle back
        pad_exp = exp_pad(dir_h[2], type_h[2], func_h[2], per_h[1]);
        // Steering uses registered config over synchronized pads
        in_exp  = exp_in(func_h[1], pad_h[2]);
        assert (digital_io_out_o === pad_exp[31:0])
          else report_mismatch("digital_io_out_o", pad_exp[31:0], digital_io_out_o);
        assert (digital_io_oen_o === pad_exp[63:32])
          else report_mismatch("digital_io_oen_o", pad_exp[63:32], digital_io_oen_o);
        assert (pad_gpio_in_o === pad_h[2])
          else report_mismatch("pad_gpio_in_o", pad_h[2], pad_gpio_in_o);
        assert (uart_rxd_o === in_exp[1:0])
          else report_mismatch("uart_rxd_o", in_exp[1:0], uart_rxd_o);
        assert (ext_intr_o === in_exp[3:2])
          else report_mismatch("ext_intr_o", in_exp[3:2], ext_intr_o);
        assert (i2c_sda_i_o === in_exp[4])
          else report_mismatch("i2c_sda_i_o", in_exp[4], i2c_sda_i_o);
        assert (i2c_scl_i_o === in_exp[5])
          else report_mismatch("i2c_scl_i_o", in_exp[5], i2c_scl_i_o);
        n_checks++;
      end
    end
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin
    logic [31:0] dir;
    logic [31:0] otype;
    logic [31:0] func;
    seed                 = 32'h3a53_c432;
    live_n               = 0;
    n_checks             = 0;
    mclk_i               = 1'b0;
    rst_i                = 1'b1;
    cfg_gpio_dir_sel_i   = '0;
    cfg_gpio_out_type_i  = '0;
    cfg_multi_func_sel_i = '0;
    gpio_out_i           = '0;
    ws_txd_i             = '0;
    pwm_wfm_i            = '0;
    uart_txd_i           = '0;
    {i2c_scl_oen_i, i2c_scl_o_i, i2c_sda_oen_i, i2c_sda_o_i} = '0;
    digital_io_in_i      = '0;
    // Eight reset cycles with outputs checked before release
    repeat (7) @(posedge mclk_i);
    @(negedge mclk_i);
    assert (digital_io_oen_o === '1)
      else report_mismatch("digital_io_oen_o", 64'hffff_ffff, digital_io_oen_o);
    assert (digital_io_out_o === '0)
      else report_mismatch("digital_io_out_o", 64'h0, digital_io_out_o);
    assert (uart_rxd_o === 2'b11)
      else report_mismatch("uart_rxd_o", 64'h3, uart_rxd_o);
    @(posedge mclk_i);
    #1;
    rst_i = 1'b0;
    wait_checker_live();
    // GPIO only with direction held while output data moves
    for (int c = 0; c < 8; c++) begin
      dir = $random(seed);
      repeat (6) drive_cycle(dir, 32'h0, 32'h0);
    end
    // Mixed functions with each setting held three cycles
    for (int c = 0; c < 60; c++) begin
      dir   = $random(seed);
      otype = $random(seed);
      func  = $random(seed);
      // Force UART 1 RX together with INT0 now and then
      if (c % 5 == 0)
        func[9:6] = func[9:6] | 4'b1001;
      repeat (3) drive_cycle(dir, otype, func);
    end
    // Drain the pipeline
    repeat (3) drive_cycle(dir, otype, func);
    // Last compare at the negedge has finished by the next rising edge
    @(negedge mclk_i);
    @(posedge mclk_i);
    if (n_checks < 200) begin
      abort_run("too few cycles were compared against the model");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

/* pinmux_top.sv */
// Pad multiplexer top
// Configuration control plus output and input pad datapaths

`include "pinmux_cfg.svh"

module pinmux_top (
  input  logic                        mclk_i,
  input  logic                        rst_i,

  // Configuration words
  input  logic [`PINMUX_PAD_CNT-1:0]  cfg_gpio_dir_sel_i,
  input  logic [`PINMUX_PAD_CNT-1:0]  cfg_gpio_out_type_i,
  input  logic [31:0]                 cfg_multi_func_sel_i,

  // GPIO
  input  logic [`PINMUX_PAD_CNT-1:0]  gpio_out_i,
  output logic [`PINMUX_PAD_CNT-1:0]  pad_gpio_in_o,

  // WS281x and PWM
  input  logic [`PINMUX_WS_CNT-1:0]   ws_txd_i,
  input  logic [`PINMUX_PWM_CNT-1:0]  pwm_wfm_i,

  // UART
  input  logic [`PINMUX_UART_CNT-1:0] uart_txd_i,
  output logic [`PINMUX_UART_CNT-1:0] uart_rxd_o,

  // Level interrupts
  output logic [1:0]                  ext_intr_o,

  // I2C master
  input  logic                        i2c_sda_o_i,
  input  logic                        i2c_sda_oen_i,
  input  logic                        i2c_scl_o_i,
  input  logic                        i2c_scl_oen_i,
  output logic                        i2c_sda_i_o,
  output logic                        i2c_scl_i_o,

  // Pads
  input  logic [`PINMUX_PAD_CNT-1:0]  digital_io_in_i,
  output logic [`PINMUX_PAD_CNT-1:0]  digital_io_out_o,
  output logic [`PINMUX_PAD_CNT-1:0]  digital_io_oen_o
);

  // Decoded selection shared by both datapaths
  pad_sel_if i_sel ();

  // ----------------------------------------------------------
  // Configuration decode
  // ----------------------------------------------------------
  pinmux_ctrl i_ctrl (
    .mclk_i               (mclk_i),
    .rst_i                (rst_i),
    .cfg_gpio_dir_sel_i   (cfg_gpio_dir_sel_i),
    .cfg_gpio_out_type_i  (cfg_gpio_out_type_i),
    .cfg_multi_func_sel_i (cfg_multi_func_sel_i),
    .sel_o                (i_sel.ctrl)
  );

  // Output side
  pad_drive i_drive (
    .mclk_i           (mclk_i),
    .rst_i            (rst_i),
    .sel_i            (i_sel.drive),
    .gpio_out_i       (gpio_out_i),
    .ws_txd_i         (ws_txd_i),
    .pwm_wfm_i        (pwm_wfm_i),
    .uart_txd_i       (uart_txd_i),
    .i2c_sda_o_i      (i2c_sda_o_i),
    .i2c_sda_oen_i    (i2c_sda_oen_i),
    .i2c_scl_o_i      (i2c_scl_o_i),
    .i2c_scl_oen_i    (i2c_scl_oen_i),
    .digital_io_out_o (digital_io_out_o),
    .digital_io_oen_o (digital_io_oen_o)
  );

  // Input side
  pad_capture i_capture (
    .mclk_i          (mclk_i),
    .rst_i           (rst_i),
    .sel_i           (i_sel.capture),
    .digital_io_in_i (digital_io_in_i),
    .pad_gpio_in_o   (pad_gpio_in_o),
    .uart_rxd_o      (uart_rxd_o),
    .ext_intr_o      (ext_intr_o),
    .i2c_sda_i_o     (i2c_sda_i_o),
    .i2c_scl_i_o     (i2c_scl_i_o)
  );

endmodule

/* pad_capture.sv */
// Pad input datapath
// Synchronizes every pad, then steers the synchronized pads to the
// GPIO input word, UART RX, level interrupts and the I2C master

`include "pinmux_cfg.svh"

module pad_capture import pinmux_pkg::*; (
  input  logic                        mclk_i,
  input  logic                        rst_i,
  pad_sel_if.capture                  sel_i,
  input  logic [`PINMUX_PAD_CNT-1:0]  digital_io_in_i,
  output logic [`PINMUX_PAD_CNT-1:0]  pad_gpio_in_o,
  output logic [`PINMUX_UART_CNT-1:0] uart_rxd_o,
  output logic [1:0]                  ext_intr_o,
  output logic                        i2c_sda_i_o,
  output logic                        i2c_scl_i_o
);

  // Synchronizer chain, stage 0 faces the pads
  logic [`PINMUX_PAD_CNT-1:0] sync_q [`PINMUX_SYNC_STAGES];
  logic [`PINMUX_PAD_CNT-1:0] pad_s;

  // ----------------------------------------------------------
  // Input synchronizer
  // ----------------------------------------------------------
  always_ff @(posedge mclk_i) begin
    if (rst_i) begin
      for (int s = 0; s < `PINMUX_SYNC_STAGES; s++)
        sync_q[s] <= '0;
    end else begin
      sync_q[0] <= digital_io_in_i;
      for (int s = 1; s < `PINMUX_SYNC_STAGES; s++)
        sync_q[s] <= sync_q[s-1];
    end
  end

  assign pad_s = sync_q[`PINMUX_SYNC_STAGES-1];

  // GPIO sees every pad whatever its owner
  assign pad_gpio_in_o = pad_s;

  // ----------------------------------------------------------
  // Peripheral input steering
  // ----------------------------------------------------------
  always_comb begin
    for (int k = 0; k < `PINMUX_UART_CNT; k++) begin
      // Idle line level when the channel is off
      uart_rxd_o[k] = sel_i.uart_rx_en[k] ? pad_s[UART_RX_PAD[k]] : 1'b1;
    end
    for (int k = 0; k < 2; k++) begin
      ext_intr_o[k] = sel_i.int_en[k] ? pad_s[INT_PAD[k]] : 1'b0;
    end
  end

  // I2C reads back both lines while enabled
  assign i2c_sda_i_o = sel_i.i2c_en ? pad_s[I2C_SDA_PAD] : 1'b0;
  assign i2c_scl_i_o = sel_i.i2c_en ? pad_s[I2C_SCL_PAD] : 1'b0;

  // Disabled RX channel stays idle high
  for (genvar k = 0; k < `PINMUX_UART_CNT; k++) begin : g_rx_chk
    a_rx_idle: assert property (@(posedge mclk_i) disable iff (rst_i)
      !sel_i.uart_rx_en[k] |-> uart_rxd_o[k]);
  end

endmodule

/* pad_drive.sv */
// Pad output datapath
// Picks each pad's data and enable from its owner, then registers both

`include "pinmux_cfg.svh"

module pad_drive import pinmux_pkg::*; (
  input  logic                        mclk_i,
  input  logic                        rst_i,
  pad_sel_if.drive                    sel_i,
  input  logic [`PINMUX_PAD_CNT-1:0]  gpio_out_i,
  input  logic [`PINMUX_WS_CNT-1:0]   ws_txd_i,
  input  logic [`PINMUX_PWM_CNT-1:0]  pwm_wfm_i,
  input  logic [`PINMUX_UART_CNT-1:0] uart_txd_i,
  input  logic                        i2c_sda_o_i,
  input  logic                        i2c_sda_oen_i,
  input  logic                        i2c_scl_o_i,
  input  logic                        i2c_scl_oen_i,
  output logic [`PINMUX_PAD_CNT-1:0]  digital_io_out_o,
  output logic [`PINMUX_PAD_CNT-1:0]  digital_io_oen_o
);

  logic [`PINMUX_PAD_CNT-1:0] out_d;
  logic [`PINMUX_PAD_CNT-1:0] oen_d;

  // ----------------------------------------------------------
  // Source select per pad
  // ----------------------------------------------------------
  always_comb begin
    for (int p = 0; p < `PINMUX_PAD_CNT; p++) begin
      // Driven unless noted
      oen_d[p] = 1'b0;
      case (sel_i.owner[p])
        OWN_GPIO:    out_d[p] = gpio_out_i[p];
        OWN_WS:      out_d[p] = ws_txd_i[sel_i.ws_ch[p]];
        OWN_PWM:     out_d[p] = pwm_wfm_i[sel_i.pwm_idx[p]];
        OWN_UART_TX: out_d[p] = uart_txd_i[sel_i.uart_tx_ch[p]];
        OWN_I2C: begin
          // Open drain, the master owns the enable
          if (pad_idx_t'(p) == I2C_SDA_PAD) begin
            out_d[p] = i2c_sda_o_i;
            oen_d[p] = i2c_sda_oen_i;
          end else begin
            out_d[p] = i2c_scl_o_i;
            oen_d[p] = i2c_scl_oen_i;
          end
        end
        default: begin
          // Input pad, released
          out_d[p] = 1'b0;
          oen_d[p] = 1'b1;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // Pad output flops
  // ----------------------------------------------------------
  always_ff @(posedge mclk_i) begin
    if (rst_i) begin
      digital_io_out_o <= '0;
      digital_io_oen_o <= '1;
    end else begin
      digital_io_out_o <= out_d;
      digital_io_oen_o <= oen_d;
    end
  end

  // Input ownership releases the pad on the next edge
  for (genvar p = 0; p < `PINMUX_PAD_CNT; p++) begin : g_oen_chk
    a_in_released: assert property (@(posedge mclk_i) disable iff (rst_i)
      sel_i.owner[p] == OWN_IN |=> digital_io_oen_o[p]);
  end

endmodule

/* pinmux_ctrl.sv */
// Pad multiplexer control
// Registers the configuration words and resolves the owner of each pad
// by fixed priority PWM, UART TX, I2C, forced input, WS, GPIO

`include "pinmux_cfg.svh"

module pinmux_ctrl import pinmux_pkg::*; (
  input  logic                       mclk_i,
  input  logic                       rst_i,
  input  logic [`PINMUX_PAD_CNT-1:0] cfg_gpio_dir_sel_i,
  input  logic [`PINMUX_PAD_CNT-1:0] cfg_gpio_out_type_i,
  input  logic [31:0]                cfg_multi_func_sel_i,
  pad_sel_if.ctrl                    sel_o
);

  logic [`PINMUX_PAD_CNT-1:0] dir_q;
  logic [`PINMUX_PAD_CNT-1:0] type_q;
  func_sel_t                  func_q;

  // Per-pad claim flags
  logic [`PINMUX_PAD_CNT-1:0] pwm_hit;
  logic [`PINMUX_PAD_CNT-1:0] tx_hit;
  logic [`PINMUX_PAD_CNT-1:0] i2c_hit;
  logic [`PINMUX_PAD_CNT-1:0] in_hit;
  logic [`PINMUX_PAD_CNT-1:0] ws_hit;
  pwm_idx_t                   pwm_k [`PINMUX_PAD_CNT];
  uart_ch_t                   tx_k  [`PINMUX_PAD_CNT];
  logic [1:0]                 int_en_m;

  // ----------------------------------------------------------
  // Configuration registers
  // ----------------------------------------------------------
  always_ff @(posedge mclk_i) begin
    if (rst_i) begin
      dir_q  <= '0;
      type_q <= '0;
      func_q <= '0;
    end else begin
      dir_q  <= cfg_gpio_dir_sel_i;
      type_q <= cfg_gpio_out_type_i;
      func_q <= func_sel_t'(cfg_multi_func_sel_i);
    end
  end

  // UART 1 RX takes pad 26 away from INT0
  assign int_en_m = func_q.int_en & ~{1'b0, func_q.uart_en[1]};

  assign sel_o.uart_rx_en = func_q.uart_en;
  assign sel_o.int_en     = int_en_m;
  assign sel_o.i2c_en     = func_q.i2c_en;

  // ----------------------------------------------------------
  // Claim decode per pad
  // ----------------------------------------------------------
  always_comb begin
    for (int p = 0; p < `PINMUX_PAD_CNT; p++) begin
      pwm_hit[p] = 1'b0;
      pwm_k[p]   = '0;
      tx_hit[p]  = 1'b0;
      tx_k[p]    = '0;
      in_hit[p]  = 1'b0;
      // At most one PWM maps to any pad
      for (int k = 0; k < `PINMUX_PWM_CNT; k++) begin
        if (func_q.pwm_en[k] && PWM_PAD[k] == pad_idx_t'(p)) begin
          pwm_hit[p] = 1'b1;
          pwm_k[p]   = pwm_idx_t'(k);
        end
      end
      for (int k = 0; k < `PINMUX_UART_CNT; k++) begin
        if (func_q.uart_en[k] && UART_TX_PAD[k] == pad_idx_t'(p)) begin
          tx_hit[p] = 1'b1;
          tx_k[p]   = uart_ch_t'(k);
        end
        // Enabled RX pad is held as input
        if (func_q.uart_en[k] && UART_RX_PAD[k] == pad_idx_t'(p))
          in_hit[p] = 1'b1;
      end
      for (int k = 0; k < 2; k++) begin
        if (int_en_m[k] && INT_PAD[k] == pad_idx_t'(p))
          in_hit[p] = 1'b1;
      end
      i2c_hit[p] = func_q.i2c_en &&
                   (pad_idx_t'(p) == I2C_SDA_PAD || pad_idx_t'(p) == I2C_SCL_PAD);
      ws_hit[p]  = type_q[p] && (PAD_WS_CH[p] != WS_NONE);
    end
  end

  // Owner by priority, source indices only matter for the matching owner
  always_comb begin
    for (int p = 0; p < `PINMUX_PAD_CNT; p++) begin
      sel_o.ws_ch[p]      = PAD_WS_CH[p][1:0];
      sel_o.pwm_idx[p]    = pwm_k[p];
      sel_o.uart_tx_ch[p] = tx_k[p];
      if (pwm_hit[p])      sel_o.owner[p] = OWN_PWM;
      else if (tx_hit[p])  sel_o.owner[p] = OWN_UART_TX;
      else if (i2c_hit[p]) sel_o.owner[p] = OWN_I2C;
      else if (in_hit[p])  sel_o.owner[p] = OWN_IN;
      else if (ws_hit[p])  sel_o.owner[p] = OWN_WS;
      else if (dir_q[p])   sel_o.owner[p] = OWN_GPIO;
      else                 sel_o.owner[p] = OWN_IN;
    end
  end

  // Each TX channel reaches at most one pad
  for (genvar c = 0; c < `PINMUX_UART_CNT; c++) begin : g_tx_once
    logic [`PINMUX_PAD_CNT-1:0] tx_use;
    always_comb begin
      for (int p = 0; p < `PINMUX_PAD_CNT; p++)
        tx_use[p] = (sel_o.owner[p] == OWN_UART_TX) && (sel_o.uart_tx_ch[p] == uart_ch_t'(c));
    end
    a_tx_once: assert property (@(posedge mclk_i) disable iff (rst_i) $onehot0(tx_use));
  end

endmodule

/* pad_sel_if.sv */
// Decoded pad selection
// Per-pad owner and source index, plus input-steering enables

`include "pinmux_cfg.svh"

interface pad_sel_if import pinmux_pkg::*; ();

  // Per-pad output selection
  pad_owner_e owner      [`PINMUX_PAD_CNT];
  ws_ch_t     ws_ch      [`PINMUX_PAD_CNT];
  pwm_idx_t   pwm_idx    [`PINMUX_PAD_CNT];
  uart_ch_t   uart_tx_ch [`PINMUX_PAD_CNT];

  // Input steering enables
  logic [`PINMUX_UART_CNT-1:0] uart_rx_en;
  // INT0 already masked against UART 1 RX
  logic [1:0]                  int_en;
  logic                        i2c_en;

  modport ctrl (
    output owner, ws_ch, pwm_idx, uart_tx_ch, uart_rx_en, int_en, i2c_en
  );

  modport drive (input owner, ws_ch, pwm_idx, uart_tx_ch);

  modport capture (input uart_rx_en, int_en, i2c_en);

endinterface

/* pinmux_pkg.sv */
// Pad multiplexer types and fixed pad maps
// Owner encoding, function-select layout and per-pad lookup tables

`include "pinmux_cfg.svh"

package pinmux_pkg;

  // Index and channel widths
  typedef logic [$clog2(`PINMUX_PAD_CNT)-1:0]  pad_idx_t;
  typedef logic [$clog2(`PINMUX_WS_CNT)-1:0]   ws_ch_t;
  typedef logic [$clog2(`PINMUX_PWM_CNT)-1:0]  pwm_idx_t;
  typedef logic [$clog2(`PINMUX_UART_CNT)-1:0] uart_ch_t;

  // Who drives a pad
  typedef enum logic [2:0] {
    OWN_IN      = 3'd0,
    OWN_GPIO    = 3'd1,
    OWN_WS      = 3'd2,
    OWN_PWM     = 3'd3,
    OWN_UART_TX = 3'd4,
    OWN_I2C     = 3'd5
  } pad_owner_e;

  // ----------------------------------------------------------
  // Function-select word, MSB first
  // ----------------------------------------------------------
  typedef struct packed {
    logic [15:0]                 rsvd_hi;
    logic                        i2c_en;
    logic [4:0]                  rsvd_lo;
    logic [`PINMUX_UART_CNT-1:0] uart_en;
    logic [1:0]                  int_en;
    logic [`PINMUX_PWM_CNT-1:0]  pwm_en;
  } func_sel_t;

  // ----------------------------------------------------------
  // Pad maps
  // ----------------------------------------------------------
  // Marker for pads without a WS channel
  localparam logic [2:0] WS_NONE = 3'd4;

  // WS channel per pad, four pads per channel
  localparam logic [2:0] PAD_WS_CH [`PINMUX_PAD_CNT] = '{
    22: 3'd0, 24: 3'd0, 25: 3'd0, 26: 3'd0,
    27: 3'd1, 28: 3'd1, 14: 3'd1, 15: 3'd1,
    29: 3'd2, 30: 3'd2, 31: 3'd2,  8: 3'd2,
     9: 3'd3, 10: 3'd3, 11: 3'd3, 12: 3'd3,
    default: WS_NONE
  };

  // PWM k lands on PWM_PAD[k]
  localparam pad_idx_t PWM_PAD [`PINMUX_PWM_CNT] = '{
    5'd27, 5'd29, 5'd30, 5'd9, 5'd10, 5'd11
  };

  // UART pads per channel
  localparam pad_idx_t UART_TX_PAD [`PINMUX_UART_CNT] = '{5'd25, 5'd28};
  localparam pad_idx_t UART_RX_PAD [`PINMUX_UART_CNT] = '{5'd24, 5'd26};

  // Level interrupt pads, INT0 shares pad 26 with UART 1 RX
  localparam pad_idx_t INT_PAD [2] = '{5'd26, 5'd27};

  // I2C master pads
  localparam pad_idx_t I2C_SDA_PAD = 5'd20;
  localparam pad_idx_t I2C_SCL_PAD = 5'd21;

endpackage

/* pinmux_cfg.svh */
// Pad multiplexer configuration
// Counts for pads, peripheral channels and input synchronizer depth

`ifndef PINMUX_CFG_SVH
`define PINMUX_CFG_SVH

// Ports A to D, eight pads each
`define PINMUX_PAD_CNT 32

// PWM waveform outputs
`define PINMUX_PWM_CNT 6

// WS281x LED driver channels
`define PINMUX_WS_CNT 4

// UART channels, one TXD and one RXD each
`define PINMUX_UART_CNT 2

// Flops between the pad and any consumer
`define PINMUX_SYNC_STAGES 2

`endif
